/* Bender.yml */
package:
  name: jpeg_capture

sources:
  - files:
      - verilog/jpeg_capture_pkg.sv
      - verilog/capture_ctrl.sv
      - verilog/rgb_to_ycbcr.sv
      - verilog/ycc_quantizer.sv
      - verilog/byte_packer.sv
      - verilog/jpeg_capture_top.sv
  - target: simulation
    files:
      - sim/jpeg_capture_assert.sv
      - sim/tb_jpeg_capture.sv

/* compile.f */
verilog/jpeg_capture_pkg.sv
verilog/capture_ctrl.sv
verilog/rgb_to_ycbcr.sv
verilog/ycc_quantizer.sv
verilog/byte_packer.sv
verilog/jpeg_capture_top.sv
sim/jpeg_capture_assert.sv
sim/tb_jpeg_capture.sv

/* sim/jpeg_capture_assert.sv */
// concurrent checks on the capture top level outputs, bound into jpeg_capture_top
`timescale 1ns/10ps

module jpeg_capture_assert
    import jpeg_capture_pkg::*;
(
    input logic              jpeg_fast_clock_in,
    input logic              jpeg_fast_reset_n_in,
    input logic              start_capture_in,
    input logic              data_valid_out,
    input logic              image_valid_out,
    input logic [addr_w-1:0] address_out
);

    int unsigned       fail_count = 0;
    logic              have_prev;   // a word of this image was already seen
    logic [addr_w-1:0] prev_addr;

    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in || image_valid_out) begin
            have_prev <= 1'b0;
            prev_addr <= '0;
        end else if (data_valid_out) begin
            have_prev <= 1'b1;
            prev_addr <= address_out;
        end
    end

    valid_exclusive: assert property (@(posedge jpeg_fast_clock_in)
        disable iff (!jpeg_fast_reset_n_in) !(data_valid_out && image_valid_out))
    else begin
        $error("data_valid_out and image_valid_out high together");
        fail_count++;
    end

    // image stays flagged until the next start
    image_hold: assert property (@(posedge jpeg_fast_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        image_valid_out && !start_capture_in |=> image_valid_out)
    else begin
        $error("image_valid_out dropped without a start");
        fail_count++;
    end

    addr_step: assert property (@(posedge jpeg_fast_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        data_valid_out |-> address_out == (have_prev ? prev_addr + addr_w'(4) : '0))
    else begin
        $error("word address did not advance by 4");
        fail_count++;
    end

endmodule

bind jpeg_capture_top jpeg_capture_assert u_jpeg_capture_assert (
    .jpeg_fast_clock_in   (jpeg_fast_clock_in),
    .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
    .start_capture_in     (start_capture_in),
    .data_valid_out       (data_valid_out),
    .image_valid_out      (image_valid_out),
    .address_out          (address_out)
);

/* sim/tb_jpeg_capture.sv */
// directed testbench for the still image capture path with a reference model and watchdog
`timescale 1ns/10ps

module tb_jpeg_capture
    import jpeg_capture_pkg::*;
();

    logic                jpeg_fast_clock_in    = 1'b0;
    logic                jpeg_fast_reset_n_in  = 1'b0;
    logic                start_capture_in      = 1'b0;
    logic [9:0]          red_data_in           = '0;
    logic [9:0]          green_data_in         = '0;
    logic [9:0]          blue_data_in          = '0;
    logic                frame_valid_in        = 1'b0;
    logic                line_valid_in         = 1'b0;
    logic [3:0]          compression_factor_in = '0;
    logic [x_size_w-1:0] x_size_in             = '0;
    logic [y_size_w-1:0] y_size_in             = '0;
    logic [31:0]         data_out;
    logic [addr_w-1:0]   address_out;
    logic                data_valid_out;
    logic                image_valid_out;

    localparam logic [29:0] fixed_colours [4] = '{30'h3ff00000, 30'h000ffc00, 30'h000003ff,
                                                   {10'd512, 10'd300, 10'd800}};

    logic [29:0]       pix_q[$];  // {r, g, b} at 10 bits each
    logic [31:0]       exp_data[$];
    logic [31:0]       got_data[$];
    logic [addr_w-1:0] exp_addr[$];
    logic [addr_w-1:0] got_addr[$];
    logic [31:0]       lcg_state = 32'hecb82e28;

    jpeg_capture_top u_jpeg_capture_top (.*);

    initial begin
        forever #50 jpeg_fast_clock_in = ~jpeg_fast_clock_in;
    end

    // collect every output word mid cycle
    always @(negedge jpeg_fast_clock_in) begin
        if (data_valid_out) begin
            got_data.push_back(data_out);
            got_addr.push_back(address_out);
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] sat_byte(int v);
        return (v < 0) ? 8'd0 : (v > 255) ? 8'd255 : v[7:0];
    endfunction

    function automatic int frame_len(int x, int y);
        return y * (2 * x + 3) + 6;  // worst case with gaps
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual)
            abort_run($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
    endtask

    task automatic next_cycle();
        @(posedge jpeg_fast_clock_in);
        #10;
    endtask

    task automatic fill_pixels(int count, bit random);
        logic [31:0] rnd;
        pix_q.delete();
        repeat (count) begin
            rnd = next_rand();
            pix_q.push_back(random ? rnd[31:2] : fixed_colours[pix_q.size() % 4]);
        end
    endtask

    // expected words from the conversion, shift and packing rules
    task automatic build_expected(int shift);
        int          r, g, b, k, l;
        logic [7:0]  bytes[$];
        logic [31:0] w;
        exp_data.delete();
        exp_addr.delete();
        foreach (pix_q[i]) begin
            r = pix_q[i][29:22];  // top 8 of each colour
            g = pix_q[i][19:12];
            b = pix_q[i][9:2];
            bytes.push_back(sat_byte((77 * r + 150 * g + 29 * b) >>> 8) >> shift);
            bytes.push_back(sat_byte(((-43 * r - 85 * g + 128 * b) >>> 8) + 128) >> shift);
            bytes.push_back(sat_byte(((128 * r - 107 * g - 21 * b) >>> 8) + 128) >> shift);
        end
        for (k = 0; k < bytes.size(); k += 4) begin
            w = '0;
            for (l = 0; l < 4 && k + l < bytes.size(); l++)
                w[8 * l +: 8] = bytes[k + l];
            exp_data.push_back(w);
            exp_addr.push_back(addr_w'(k));  // byte address of the word
        end
    endtask

    task automatic drive_frame(int x, int y, bit gaps, int start_row);
        int row, col;
        int idx = 0;
        x_size_in      = x_size_w'(x);
        y_size_in      = y_size_w'(y);
        frame_valid_in = 1'b1;
        next_cycle();
        for (row = 0; row < y; row++) begin
            for (col = 0; col < x; col++) begin
                if (gaps && col % 2 == 1) begin
                    line_valid_in = 1'b0;  // hole inside the line
                    next_cycle();
                end
                start_capture_in = (row == start_row) && (col == 0);
                line_valid_in    = 1'b1;
                {red_data_in, green_data_in, blue_data_in} = pix_q[idx];
                idx++;
                next_cycle();
            end
            start_capture_in = 1'b0;
            line_valid_in    = 1'b0;
            repeat (3) next_cycle();
        end
        frame_valid_in = 1'b0;
        repeat (4) next_cycle();
    endtask

    task automatic pulse_start();
        start_capture_in = 1'b1;
        next_cycle();
        start_capture_in = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic wait_image(string name);
        int cycles = 0;
        while (image_valid_out !== 1'b1) begin
            if (cycles == 64)
                abort_run($sformatf("%s: image_valid_out never came up", name));
            cycles++;
            next_cycle();
        end
    endtask

    task automatic compare_words(string name, int x, int y);
        check($sformatf("%s word count", name), exp_data.size(), got_data.size());
        foreach (exp_data[i]) begin
            check($sformatf("%s data %0d", name, i), exp_data[i], got_data[i]);
            check($sformatf("%s addr %0d", name, i), exp_addr[i], got_addr[i]);
        end
        check($sformatf("%s byte count", name), 3 * x * y, address_out);
    endtask

    task automatic capture_frame(string name, int x, int y, int factor, int shift, bit gaps,
                                 bit random);
        compression_factor_in = 4'(factor);
        fill_pixels(x * y, random);
        build_expected(shift);
        got_data.delete();
        got_addr.delete();
        pulse_start();
        drive_frame(x, y, gaps, -1);
        wait_image(name);
        compare_words(name, x, y);
    endtask

    task automatic idle_quiet();
        fill_pixels(8, 1'b0);
        drive_frame(4, 2, 1'b0, -1);
        repeat (16) next_cycle();
        check("idle_quiet words", 0, got_data.size());
        check("idle_quiet image valid", 0, image_valid_out);
    endtask

    task automatic single_frame();
        capture_frame("single_frame", 4, 2, 0, 0, 1'b0, 1'b0);
        check("single_frame words", 6, got_data.size());
    endtask

    task automatic partial_word();
        capture_frame("partial_word", 5, 3, 2, 2, 1'b0, 1'b1);
        check("partial_word words", 12, got_data.size());
        check("partial_word pad", 0, got_data[11][31:8]);
    endtask

    task automatic start_mid_frame();
        compression_factor_in = 4'd1;
        got_data.delete();
        got_addr.delete();
        fill_pixels(18, 1'b1);
        drive_frame(6, 3, 1'b0, 1);  // start lands at the head of row 1
        fill_pixels(18, 1'b1);
        build_expected(1);
        drive_frame(6, 3, 1'b0, -1);
        wait_image("start_mid_frame");
        compare_words("start_mid_frame", 6, 3);
    endtask

    task automatic gaps_and_clamp();
        capture_frame("gaps_and_clamp", 6, 2, 12, 7, 1'b1, 1'b1);
    endtask

    task automatic recapture();
        pulse_start();
        check("recapture image valid", 0, image_valid_out);
        capture_frame("recapture", 4, 2, 3, 3, 1'b0, 1'b1);
        check("recapture first addr", 0, got_addr[0]);
    endtask

    initial begin
        repeat (16) @(posedge jpeg_fast_clock_in);
        #10;
        jpeg_fast_reset_n_in = 1'b1;
        next_cycle();
        idle_quiet();
        single_frame();
        partial_word();
        start_mid_frame();
        gaps_and_clamp();
        recapture();
        if (u_jpeg_capture_top.u_jpeg_capture_assert.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("assertion failures were reported during the run");
        end
    end

    // stop at the first bound assertion failure
    initial begin
        wait (u_jpeg_capture_top.u_jpeg_capture_assert.fail_count != 0);
        abort_run("a bound assertion on the DUT outputs failed");
    end

    // frame budget covers every frame the tests drive
    initial begin
        repeat (16 + 4 * (3 * frame_len(4, 2) + frame_len(5, 3) + 2 * frame_len(6, 3)
                + frame_len(6, 2)) + 200) @(posedge jpeg_fast_clock_in);
        abort_run("the run timed out before all tests finished");
    end

endmodule

/* verilog/byte_packer.sv */
// byte packer that turns y, cb, cr bytes into addressed 32-bit words and flushes the tail
`timescale 1ns/10ps

module byte_packer
    import jpeg_capture_pkg::*;
(
    input  logic              jpeg_fast_clock_in,
    input  logic              jpeg_fast_reset_n_in,
    input  logic              pipe_clear,
    input  qpix_t             qpix,
    input  logic              qpix_valid,
    output out_word_t         word,
    output logic              word_valid,
    output logic [addr_w-1:0] byte_count
);

    logic [23:0]       pend_q;     // pending bytes, lane 0 lowest
    logic [1:0]        lane_cnt;   // number of pending bytes
    logic              flush_q;    // tail word still owed after the last pixel
    logic [addr_w-1:0] word_addr;
    logic [23:0]       pend_keep;
    logic [23:0]       new_bytes;
    logic [47:0]       merged;
    logic [2:0]        total;

    always_comb begin
        pend_keep = pend_q & ~({24{1'b1}} << {lane_cnt, 3'b000});  // drop stale lanes
        new_bytes = {qpix.ycc.cr, qpix.ycc.cb, qpix.ycc.y};
        merged    = ({24'd0, new_bytes} << {lane_cnt, 3'b000}) | {24'd0, pend_keep};
        total     = {1'b0, lane_cnt} + 3'd3;
    end

    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in || pipe_clear) begin
            lane_cnt   <= '0;
            flush_q    <= 1'b0;
            word_valid <= 1'b0;
            word_addr  <= '0;
            byte_count <= '0;
        end else begin
            word_valid <= 1'b0;
            flush_q    <= 1'b0;
            if (flush_q) begin
                word_valid <= 1'b1;
                word_addr  <= word_addr + 16'd4;
                lane_cnt   <= '0;
            end else if (qpix_valid) begin
                byte_count <= byte_count + 16'd3;
                if (total[2]) begin  // four or more bytes, a full word goes out
                    word_valid <= 1'b1;
                    word_addr  <= word_addr + 16'd4;
                    lane_cnt   <= total[1:0];
                    flush_q    <= qpix.last && (total[1:0] != 2'd0);
                end else if (qpix.last) begin
                    word_valid <= 1'b1;
                    word_addr  <= word_addr + 16'd4;
                    lane_cnt   <= '0;
                end else begin
                    lane_cnt <= 2'd3;
                end
            end
        end
    end

    always_ff @(posedge jpeg_fast_clock_in) begin
        if (flush_q) begin
            word.data <= {8'd0, pend_keep};  // unused lanes stay zero
            word.addr <= word_addr;
            word.last <= 1'b1;
        end else if (qpix_valid) begin
            word.data <= merged[31:0];
            word.addr <= word_addr;
            word.last <= qpix.last && !(total[2] && (total[1:0] != 2'd0));
            pend_q    <= total[2] ? {8'd0, merged[47:32]} : merged[23:0];
        end
    end

endmodule

/* verilog/capture_ctrl.sv */
// capture controller FSM that arms the datapath for one full frame and flags image completion
`timescale 1ns/10ps

module capture_ctrl
    import jpeg_capture_pkg::*;
(
    input  logic jpeg_fast_clock_in,
    input  logic jpeg_fast_reset_n_in,
    input  logic start_capture_in,
    input  logic frame_valid_in,
    input  logic image_done,
    output logic capture_en,
    output logic pipe_clear,
    output logic image_valid
);

    capture_state_t state;

    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in) begin
            state <= idle;
        end else begin
            case (state)
                // hold the datapath cleared until the running frame is over
                clear: begin
                    if (!frame_valid_in) state <= wait_frame_start;
                end
                wait_frame_start: begin
                    if (frame_valid_in) state <= compress;
                end
                compress: begin
                    if (image_done) state <= jpeg_capture_pkg::image_valid;
                end
                default: begin  // idle, or an image is ready
                    if (start_capture_in) state <= clear;
                end
            endcase
        end
    end

    always_comb begin
        capture_en  = (state == wait_frame_start) || (state == compress);
        pipe_clear  = (state == clear);
        image_valid = (state == jpeg_capture_pkg::image_valid);
    end

endmodule

/* verilog/jpeg_capture_pkg.sv */
// jpeg capture package with shared sizes, datapath structs and the controller state encoding
package jpeg_capture_pkg;

    localparam int unsigned pix_w     = 8;   // bits per colour component after trimming
    localparam int unsigned x_size_w  = 11;  // line length input width
    localparam int unsigned y_size_w  = 10;  // frame height input width
    localparam int unsigned addr_w    = 16;  // byte address width
    localparam int unsigned max_shift = 7;   // compression factor clamp

    // trimmed sensor pixel
    typedef struct packed {
        logic [pix_w-1:0] r;
        logic [pix_w-1:0] g;
        logic [pix_w-1:0] b;
    } rgb_pixel_t;

    // converted pixel, y goes out first in the byte stream
    typedef struct packed {
        logic [pix_w-1:0] y;
        logic [pix_w-1:0] cb;
        logic [pix_w-1:0] cr;
    } ycc_pixel_t;

    typedef struct packed {
        ycc_pixel_t ycc;
        logic       last;  // final pixel of the frame
    } qpix_t;

    typedef struct packed {
        logic [31:0]       data;
        logic [addr_w-1:0] addr;
        logic              last;
    } out_word_t;

    typedef enum logic [2:0] {
        idle,
        clear,
        wait_frame_start,
        compress,
        image_valid
    } capture_state_t;

endpackage

/* verilog/jpeg_capture_top.sv */
// still image capture top level with sensor trimming, capture gating and the encode datapath
`timescale 1ns/10ps

module jpeg_capture_top
    import jpeg_capture_pkg::*;
(
    input  logic                jpeg_fast_clock_in,
    input  logic                jpeg_fast_reset_n_in,
    input  logic                start_capture_in,
    input  logic [9:0]          red_data_in,
    input  logic [9:0]          green_data_in,
    input  logic [9:0]          blue_data_in,
    input  logic                frame_valid_in,
    input  logic                line_valid_in,
    input  logic [3:0]          compression_factor_in,
    input  logic [x_size_w-1:0] x_size_in,
    input  logic [y_size_w-1:0] y_size_in,
    output logic [31:0]         data_out,
    output logic [addr_w-1:0]   address_out,
    output logic                data_valid_out,
    output logic                image_valid_out
);

    logic              capture_en;
    logic              pipe_clear;
    logic              image_done;
    logic              pix_valid;
    rgb_pixel_t        pix;
    ycc_pixel_t        ycc;
    logic              ycc_valid;
    qpix_t             qpix;
    logic              qpix_valid;
    out_word_t         word;
    logic              word_valid;
    logic [addr_w-1:0] byte_count;

    always_comb begin
        pix_valid = capture_en & frame_valid_in & line_valid_in;
        pix.r     = red_data_in[9:2];  // keep the top 8 of 10 bits
        pix.g     = green_data_in[9:2];
        pix.b     = blue_data_in[9:2];
    end

    capture_ctrl u_capture_ctrl (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .start_capture_in     (start_capture_in),
        .frame_valid_in       (frame_valid_in),
        .image_done           (image_done),
        .capture_en           (capture_en),
        .pipe_clear           (pipe_clear),
        .image_valid          (image_valid_out)
    );

    rgb_to_ycbcr u_rgb_to_ycbcr (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .pipe_clear           (pipe_clear),
        .pix                  (pix),
        .pix_valid            (pix_valid),
        .ycc                  (ycc),
        .ycc_valid            (ycc_valid)
    );

    ycc_quantizer u_ycc_quantizer (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .pipe_clear           (pipe_clear),
        .ycc                  (ycc),
        .ycc_valid            (ycc_valid),
        .compression_factor   (compression_factor_in),
        .x_size               (x_size_in),
        .y_size               (y_size_in),
        .qpix                 (qpix),
        .qpix_valid           (qpix_valid)
    );

    byte_packer u_byte_packer (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .pipe_clear           (pipe_clear),
        .qpix                 (qpix),
        .qpix_valid           (qpix_valid),
        .word                 (word),
        .word_valid           (word_valid),
        .byte_count           (byte_count)
    );

    // the end of image is the last word of the frame
    always_comb begin
        image_done     = word_valid & word.last;
        data_out       = word.data;
        data_valid_out = word_valid;
        address_out    = image_valid_out ? byte_count : word.addr;  // total size once done
    end

endmodule

/* verilog/rgb_to_ycbcr.sv */
// two stage integer rgb to ycbcr converter with offset and saturation
`timescale 1ns/10ps

module rgb_to_ycbcr
    import jpeg_capture_pkg::*;
(
    input  logic       jpeg_fast_clock_in,
    input  logic       jpeg_fast_reset_n_in,
    input  logic       pipe_clear,
    input  rgb_pixel_t pix,
    input  logic       pix_valid,
    output ycc_pixel_t ycc,
    output logic       ycc_valid
);

    logic signed [17:0] r_s, g_s, b_s;  // zero extended components
    logic signed [17:0] prod_q [0:8];   // y, cb, cr rows of three products
    logic               prod_valid_q;
    logic signed [19:0] sum_y, sum_cb, sum_cr;

    function automatic logic [pix_w-1:0] sat8(input logic signed [19:0] v);
        if (v < 0)
            return '0;
        else if (v > 20'sd255)
            return '1;
        else
            return v[pix_w-1:0];
    endfunction

    always_comb begin
        r_s = {10'd0, pix.r};
        g_s = {10'd0, pix.g};
        b_s = {10'd0, pix.b};
    end

    // stage one, coefficient products
    always_ff @(posedge jpeg_fast_clock_in) begin
        prod_q[0] <= r_s * 18'sd77;
        prod_q[1] <= g_s * 18'sd150;
        prod_q[2] <= b_s * 18'sd29;
        prod_q[3] <= r_s * -18'sd43;
        prod_q[4] <= g_s * -18'sd85;
        prod_q[5] <= b_s * 18'sd128;
        prod_q[6] <= r_s * 18'sd128;
        prod_q[7] <= g_s * -18'sd107;
        prod_q[8] <= b_s * -18'sd21;
    end

    // stage two, sum and arithmetic shift by 8
    always_comb begin
        sum_y  = (prod_q[0] + prod_q[1] + prod_q[2]) >>> 8;
        sum_cb = ((prod_q[3] + prod_q[4] + prod_q[5]) >>> 8) + 20'sd128;
        sum_cr = ((prod_q[6] + prod_q[7] + prod_q[8]) >>> 8) + 20'sd128;
    end

    always_ff @(posedge jpeg_fast_clock_in) begin
        ycc.y  <= sat8(sum_y);
        ycc.cb <= sat8(sum_cb);
        ycc.cr <= sat8(sum_cr);
    end

    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in || pipe_clear) begin
            prod_valid_q <= 1'b0;
            ycc_valid    <= 1'b0;
        end else begin
            prod_valid_q <= pix_valid;
            ycc_valid    <= prod_valid_q;
        end
    end

endmodule

/* verilog/ycc_quantizer.sv */
// component shift scaling and raster position tracking that marks the frame's last pixel
`timescale 1ns/10ps

module ycc_quantizer
    import jpeg_capture_pkg::*;
(
    input  logic                jpeg_fast_clock_in,
    input  logic                jpeg_fast_reset_n_in,
    input  logic                pipe_clear,
    input  ycc_pixel_t          ycc,
    input  logic                ycc_valid,
    input  logic [3:0]          compression_factor,
    input  logic [x_size_w-1:0] x_size,
    input  logic [y_size_w-1:0] y_size,
    output qpix_t               qpix,
    output logic                qpix_valid
);

    logic [2:0]          shift;
    logic [x_size_w-1:0] col;
    logic [y_size_w-1:0] row;
    logic                end_of_line;

    always_comb begin
        shift = (compression_factor > 4'(max_shift)) ? 3'(max_shift) : compression_factor[2:0];
        end_of_line = (col == x_size - 11'd1);
    end

    // column and row advance on valid pixels only, line gaps don't matter
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in || pipe_clear) begin
            col        <= '0;
            row        <= '0;
            qpix_valid <= 1'b0;
        end else begin
            qpix_valid <= ycc_valid;
            if (ycc_valid) begin
                col <= end_of_line ? '0 : col + 11'd1;
                if (end_of_line) row <= row + 10'd1;
            end
        end
    end

    always_ff @(posedge jpeg_fast_clock_in) begin
        qpix.ycc.y  <= ycc.y >> shift;
        qpix.ycc.cb <= ycc.cb >> shift;
        qpix.ycc.cr <= ycc.cr >> shift;
        qpix.last   <= end_of_line && (row == y_size - 10'd1);
    end

endmodule
